// File: src/mmio_pkg.sv
package mmio_pkg;

    // address map, all windows aligned to their own size
    localparam logic [31:0] ram_base      = 32'h0000_0000;
    localparam logic [31:0] ram_limit     = 32'h0000_0FFF;
    localparam logic [31:0] keypad_addr   = 32'h0000_F000;
    localparam logic [31:0] display_base  = 32'h0001_0000;
    localparam logic [31:0] display_limit = 32'h0001_FFFF;

    // sram geometry follows from the ram window
    localparam int unsigned ram_words = (ram_limit - ram_base + 1) / 4;
    localparam int unsigned ram_aw    = $clog2(ram_words);

    // load value for unmapped addresses
    localparam logic [31:0] err_word = 32'hDEADBEEF;

    typedef enum logic [1:0] {
        region_ram,
        region_keypad,
        region_display,
        region_none
    } region_t;

    typedef enum logic [1:0] {
        op_idle,
        op_load,
        op_store
    } mem_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_ram,
        st_key,
        st_disp,
        st_done
    } bus_state_t;

    typedef struct packed {
        mem_op_t     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        cpu_req_t req;
        region_t  region;
    } dec_req_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // keypad word as seen by a cpu load
    typedef struct packed {
        logic        valid;
        logic [23:0] zero;
        logic [1:0]  app;
        logic [4:0]  button;
    } key_word_t;

    typedef struct packed {
        logic        pulse;
        region_t     region;
        mem_op_t     op;
        logic [31:0] rdata;
    } done_t;

endpackage

// File: src/mmio_addr_decode.sv
`timescale 1ns/100ps

module mmio_addr_decode (
    input  mmio_pkg::cpu_req_t req,
    output mmio_pkg::dec_req_t dec
);
    import mmio_pkg::*;

    logic hit_ram;
    logic hit_key;
    logic hit_disp;

    // windows are power-of-two sized and aligned, so masking the offset bits
    // and comparing against the base is enough
    function automatic logic in_window(
        input logic [31:0] addr,
        input logic [31:0] base,
        input logic [31:0] limit
    );
        logic [31:0] span;
        span = limit - base;
        return (addr & ~span) == base;
    endfunction

    assign hit_ram  = in_window(req.addr, ram_base, ram_limit);
    // keypad is a single word, byte offset ignored
    assign hit_key  = in_window(req.addr, keypad_addr, keypad_addr + 32'd3);
    assign hit_disp = in_window(req.addr, display_base, display_limit);

    always_comb begin
        dec.req = req;
        if (hit_ram) begin
            dec.region = region_ram;
        end else if (hit_key) begin
            dec.region = region_keypad;
        end else if (hit_disp) begin
            dec.region = region_display;
        end else begin
            dec.region = region_none;
        end
    end

endmodule

// File: src/mmio_bus_engine.sv
`timescale 1ns/100ps

module mmio_bus_engine (
    input  logic                clk,
    input  logic                reset,
    input  mmio_pkg::dec_req_t  dec,
    output mmio_pkg::wb_req_t   wb_req,
    input  mmio_pkg::wb_rsp_t   wb_rsp,
    output logic                key_rd,
    input  mmio_pkg::key_word_t key_data,
    output logic [31:0]         display_addr,
    output logic [31:0]         display_data,
    output logic                display_wen,
    input  logic                display_ack,
    output mmio_pkg::done_t     done
);
    import mmio_pkg::*;

    bus_state_t state;
    bus_state_t next_state;
    dec_req_t   cur;
    dec_req_t   src;
    logic       key_wait;
    logic       accept;

    assign accept = (state == st_idle) && (dec.req.op != op_idle);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    case (dec.region)
                        region_ram:     next_state = st_ram;
                        region_keypad:  next_state = st_key;
                        // display only takes stores, loads finish at once
                        region_display: next_state = (dec.req.op == op_store) ? st_disp : st_done;
                        default:        next_state = st_done;
                    endcase
                end
            end
            st_ram: begin
                if (wb_rsp.ack) begin
                    next_state = st_done;
                end
            end
            st_key: begin
                if (key_wait) begin
                    next_state = st_done;
                end
            end
            st_disp: begin
                if (display_ack) begin
                    next_state = st_done;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= st_idle;
            key_wait <= 1'b0;
        end else begin
            state    <= next_state;
            // second cycle in st_key
            key_wait <= (state == st_key) && !key_wait;
        end
    end

    // request is held here for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= dec;
        end
    end

    // wishbone manager side
    assign wb_req.cyc = (state == st_ram);
    assign wb_req.stb = (state == st_ram);
    assign wb_req.we  = (cur.req.op == op_store);
    assign wb_req.adr = cur.req.addr;
    assign wb_req.dat = cur.req.wdata;

    // only a load consumes the key code
    assign key_rd = (state == st_key) && key_wait && (cur.req.op == op_load);

    assign display_addr = cur.req.addr;
    assign display_data = cur.req.wdata;
    assign display_wen  = (state == st_disp);

    // unmapped requests finish straight from idle, before cur is loaded
    assign src = (state == st_idle) ? dec : cur;

    // done fires on the edge into st_done, so d_ack lines up with st_done
    // and the still-held cpu request is ignored there
    always_comb begin
        done.pulse  = (state != st_done) && (next_state == st_done);
        done.region = src.region;
        done.op     = src.req.op;
        case (state)
            st_ram:  done.rdata = wb_rsp.dat;
            st_key:  done.rdata = key_data;
            default: done.rdata = '0;
        endcase
    end

endmodule

// File: src/mmio_keypad_reg.sv
`timescale 1ns/100ps

module mmio_keypad_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          button,
    input  logic [1:0]          app,
    input  logic                key_strobe,
    input  logic                key_rd,
    output mmio_pkg::key_word_t key_data
);

    logic       valid_q;
    logic [1:0] app_q;
    logic [4:0] button_q;

    // latest strobe always overwrites the stored code
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            app_q    <= '0;
            button_q <= '0;
        end else if (key_strobe) begin
            app_q    <= app;
            button_q <= button;
        end
    end

    // set by a strobe, cleared by a read
    // strobe wins when both land together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (key_strobe) begin
            valid_q <= 1'b1;
        end else if (key_rd) begin
            valid_q <= 1'b0;
        end
    end

    assign key_data.valid  = valid_q;
    assign key_data.zero   = '0;
    assign key_data.app    = app_q;
    assign key_data.button = button_q;

endmodule

// File: src/mmio_response.sv
`timescale 1ns/100ps

module mmio_response (
    input  logic            clk,
    input  logic            reset,
    input  mmio_pkg::done_t done,
    output logic [31:0]     load_data,
    output logic            d_ack
);
    import mmio_pkg::*;

    logic [31:0] sel_data;

    // stores return zero, unmapped loads return the error word
    always_comb begin
        if (done.op == op_load) begin
            if (done.region == region_none) begin
                sel_data = err_word;
            end else begin
                sel_data = done.rdata;
            end
        end else begin
            sel_data = '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            d_ack <= 1'b0;
        end else begin
            d_ack <= done.pulse;
        end
    end

    // load data stays put until the next access completes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_data <= '0;
        end else if (done.pulse) begin
            load_data <= sel_data;
        end
    end

endmodule

// File: src/mmio_sram_wb.sv
`timescale 1ns/100ps

module mmio_sram_wb (
    input  logic              clk,
    input  logic              reset,
    input  mmio_pkg::wb_req_t wb_req,
    output mmio_pkg::wb_rsp_t wb_rsp
);
    import mmio_pkg::*;

    logic [31:0]       mem [ram_words];
    logic [ram_aw-1:0] widx;
    logic              ack_q;
    logic [31:0]       rdat_q;
    logic              take;

    // word index from the byte address
    assign widx = wb_req.adr[ram_aw+1:2];

    // first cycle of a strobe, the ack cycle itself is skipped
    assign take = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (wb_req.we) begin
                mem[widx] <= wb_req.dat;
            end
            rdat_q <= mem[widx];
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

endmodule

// File: src/mmio_top.sv
`timescale 1ns/100ps

module mmio_top (
    input  logic               clk,
    input  logic               reset,
    input  mmio_pkg::cpu_req_t cpu_req,
    output logic [31:0]        load_data,
    output logic               d_ack,
    input  logic [4:0]         button,
    input  logic [1:0]         app,
    input  logic               key_strobe,
    output logic [31:0]        display_addr,
    output logic [31:0]        display_data,
    output logic               display_wen,
    input  logic               display_ack
);
    import mmio_pkg::*;

    dec_req_t  dec;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    key_word_t key_data;
    logic      key_rd;
    done_t     done;

    mmio_addr_decode decode_i (
        .req (cpu_req),
        .dec (dec)
    );

    mmio_bus_engine engine_i (
        .clk          (clk),
        .reset        (reset),
        .dec          (dec),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .key_rd       (key_rd),
        .key_data     (key_data),
        .display_addr (display_addr),
        .display_data (display_data),
        .display_wen  (display_wen),
        .display_ack  (display_ack),
        .done         (done)
    );

    mmio_keypad_reg keypad_i (
        .clk        (clk),
        .reset      (reset),
        .button     (button),
        .app        (app),
        .key_strobe (key_strobe),
        .key_rd     (key_rd),
        .key_data   (key_data)
    );

    mmio_response response_i (
        .clk       (clk),
        .reset     (reset),
        .done      (done),
        .load_data (load_data),
        .d_ack     (d_ack)
    );

    // internal ram behind the wishbone manager
    mmio_sram_wb sram_i (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

endmodule

// File: bench/mmio_props.sv
`timescale 1ns/100ps

module mmio_props (
    input logic                 clk,
    input logic                 reset,
    input mmio_pkg::bus_state_t state,
    input mmio_pkg::wb_req_t    wb_req,
    input mmio_pkg::wb_rsp_t    wb_rsp,
    input logic                 display_wen,
    input logic                 display_ack,
    input mmio_pkg::done_t      done
);
    import mmio_pkg::*;

    int fail_count = 0;

    // wishbone request held with steady fields until the sram acks
    wb_hold: assert property (@(posedge clk) disable iff (reset)
        (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=>
            (wb_req.cyc && wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we)
             && $stable(wb_req.dat)))
        else begin
            fail_count++;
            $error("wishbone cyc/stb dropped or changed before ack");
        end

    disp_hold: assert property (@(posedge clk) disable iff (reset)
        (display_wen && !display_ack) |=> display_wen)
        else begin
            fail_count++;
            $error("display_wen dropped before display_ack");
        end

    // each sram ack closes its access with exactly one done pulse
    done_on_ack: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |-> done.pulse)
        else begin
            fail_count++;
            $error("sram ack without a matching done pulse");
        end

    // st_key lasts exactly two cycles
    key_enter: assert property (@(posedge clk) disable iff (reset)
        (state == st_key && $past(state) != st_key) |=> (state == st_key))
        else begin
            fail_count++;
            $error("engine left st_key after one cycle");
        end

    key_leave: assert property (@(posedge clk) disable iff (reset)
        (state == st_key && $past(state) == st_key) |=> (state != st_key))
        else begin
            fail_count++;
            $error("engine stayed in st_key for more than two cycles");
        end

endmodule

// File: bench/mmio_tb.sv
`timescale 1ns/100ps

module mmio_tb;
    import mmio_pkg::*;

    localparam int clk_period          = 8;
    localparam int reset_cycles        = 8;
    localparam int ram_count           = 16;
    // reset_state, ram_rw, keypad, display, unmapped
    localparam int transfer_count      = 1 + 2 * ram_count + 3 + 3 + 4;
    localparam int cycles_per_transfer = 20;

    logic        clk;
    logic        reset;
    cpu_req_t    cpu_req;
    logic [31:0] load_data;
    logic        d_ack;
    logic [4:0]  button;
    logic [1:0]  app;
    logic        key_strobe;
    logic [31:0] display_addr;
    logic [31:0] display_data;
    logic        display_wen;
    logic        display_ack;

    logic [31:0] rand_state = 32'heb43ec73;
    // what the display responder saw on its last ack
    logic [31:0] seen_addr;
    logic [31:0] seen_data;
    int          ack_count;

    mmio_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .load_data    (load_data),
        .d_ack        (d_ack),
        .button       (button),
        .app          (app),
        .key_strobe   (key_strobe),
        .display_addr (display_addr),
        .display_data (display_data),
        .display_wen  (display_wen),
        .display_ack  (display_ack)
    );

    bind mmio_bus_engine mmio_props props_i (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .display_wen (display_wen),
        .display_ack (display_ack),
        .done        (done)
    );

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "%s: value mismatch", name);
        end
    endtask

    // request is held until d_ack, then op_idle for one cycle
    task automatic run_access(input mem_op_t op, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        cpu_req.op    = op;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        do begin
            @(posedge clk);
            #1;
        end while (!d_ack);
        rdata      = load_data;
        cpu_req.op = op_idle;
        @(posedge clk);
        #1;
    endtask

    task automatic cpu_load(input logic [31:0] addr, output logic [31:0] data);
        run_access(op_load, addr, 32'h0, data);
    endtask

    task automatic cpu_store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        run_access(op_store, addr, data, unused);
    endtask

    task automatic pulse_key(input logic [4:0] b, input logic [1:0] a);
        button     = b;
        app        = a;
        key_strobe = 1'b1;
        @(posedge clk);
        #1;
        key_strobe = 1'b0;
    endtask

    task automatic reset_state_test();
        logic [31:0] data;
        check("reset_state", 32'h0, {31'h0, d_ack});
        check("reset_state", 32'h0, {31'h0, display_wen});
        cpu_load(keypad_addr, data);
        check("reset_state", 32'h0, data);
    endtask

    task automatic ram_rw_test();
        logic [31:0] addrs [ram_count];
        logic [31:0] scoreboard [logic [31:0]];
        logic [31:0] r;
        logic [31:0] data;
        for (int i = 0; i < ram_count; i++) begin
            r        = next_rand();
            addrs[i] = {20'h0, r[11:2], 2'b00};
            data     = next_rand();
            scoreboard[addrs[i]] = data;
            cpu_store(addrs[i], data);
        end
        for (int i = 0; i < ram_count; i++) begin
            cpu_load(addrs[i], data);
            check("ram_rw", scoreboard[addrs[i]], data);
        end
    endtask

    task automatic keypad_test();
        logic [31:0] data;
        pulse_key(5'h13, 2'h2);
        cpu_load(keypad_addr, data);
        check("keypad", {1'b1, 24'h0, 2'h2, 5'h13}, data);
        // read clears valid but keeps the code
        cpu_load(keypad_addr, data);
        check("keypad", {1'b0, 24'h0, 2'h2, 5'h13}, data);
        pulse_key(5'h05, 2'h1);
        pulse_key(5'h1e, 2'h3);
        cpu_load(keypad_addr, data);
        check("keypad", {1'b1, 24'h0, 2'h3, 5'h1e}, data);
    endtask

    task automatic display_test();
        logic [31:0] addrs [3];
        logic [31:0] data;
        int          prev;
        addrs = '{32'h0001_0000, 32'h0001_0abc, 32'h0001_fffc};
        for (int i = 0; i < 3; i++) begin
            data = next_rand();
            prev = ack_count;
            cpu_store(addrs[i], data);
            check("display", addrs[i], seen_addr);
            check("display", data, seen_data);
            check("display", prev + 1, ack_count);
            check("display", 32'h0, {31'h0, display_wen});
        end
    endtask

    task automatic unmapped_test();
        logic [31:0] data;
        cpu_store(32'h0000_0000, 32'h600d_f00d);
        cpu_load(32'h0000_8000, data);
        check("unmapped", 32'hdead_beef, data);
        // low bits of 0x8000 alias ram word 0 if decode is wrong
        cpu_store(32'h0000_8000, 32'h0bad_cafe);
        cpu_load(32'h0000_0000, data);
        check("unmapped", 32'h600d_f00d, data);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // display side, acks after 0 to 3 cycles
    initial begin
        int          delay;
        logic [31:0] r;
        forever begin
            @(posedge clk);
            #1;
            if (display_wen) begin
                r     = next_rand();
                delay = int'(r[17:16]);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                    check("display", 32'h1, {31'h0, display_wen});
                end
                seen_addr   = display_addr;
                seen_data   = display_data;
                ack_count   = ack_count + 1;
                display_ack = 1'b1;
                @(posedge clk);
                #1;
                display_ack = 1'b0;
            end
        end
    end

    initial begin
        #((reset_cycles + transfer_count * cycles_per_transfer) * clk_period);
        $display("timeout: tests did not finish within %0d transfers of %0d cycles",
                 transfer_count, cycles_per_transfer);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset         = 1'b1;
        cpu_req.op    = op_idle;
        cpu_req.addr  = 32'h0;
        cpu_req.wdata = 32'h0;
        button        = 5'h0;
        app           = 2'h0;
        key_strobe    = 1'b0;
        display_ack   = 1'b0;
        seen_addr     = 32'h0;
        seen_data     = 32'h0;
        ack_count     = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        reset_state_test();
        ram_rw_test();
        keypad_test();
        display_test();
        unmapped_test();
        if (dut_i.engine_i.props_i.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "assertion failures in the bus engine");
        end
    end

endmodule

// File: mmio.f
src/mmio_pkg.sv
src/mmio_addr_decode.sv
src/mmio_bus_engine.sv
src/mmio_keypad_reg.sv
src/mmio_response.sv
src/mmio_sram_wb.sv
src/mmio_top.sv
bench/mmio_props.sv
bench/mmio_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := mmio_tb
FILELIST  := mmio.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^>>> PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
